// ==== design/core_pkg.sv ====
// Shared types and constants for the RV32I integer datapath
// Loads, stores and CSRs are not part of this subset

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  addr_t;

    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW    = 6;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Source of a register operand in decode
    typedef enum logic [1:0] {RS_RF, RS_ALU, RS_WB} rs_t;

    typedef enum logic {OP1_RS1, OP1_PC} op1_t;

    typedef enum logic [2:0] {
        OP2_RS2, OP2_I_IMM, OP2_B_IMM, OP2_U_IMM, OP2_J_IMM
    } op2_t;

    // Execute class
    typedef enum logic [2:0] {
        OP_NULL, OP_ALU, OP_BRANCH, OP_JAL, OP_JALR, OP_LUI
    } op_t;

    typedef enum logic [3:0] {
        FUN_ADD, FUN_SUB, FUN_AND, FUN_OR, FUN_XOR,
        FUN_SLT, FUN_SLTU, FUN_SLL, FUN_SRL, FUN_SRA
    } fun_t;

    // One instruction word, viewed in each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            addr_t      rs2;
            addr_t      rs1;
            logic [2:0] funct3;
            addr_t      rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            addr_t       rs1;
            logic [2:0]  funct3;
            addr_t       rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            addr_t      rs2;
            addr_t      rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            addr_t      rs2;
            addr_t      rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } sb;
        struct packed {
            logic [19:0] imm_31_12;
            addr_t       rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            addr_t      rd;
            logic [6:0] opcode;
        } uj;
    } inst_t;

    typedef struct packed {
        op_t        op;
        fun_t       fun;
        logic [2:0] funct3;
        op1_t       op1;
        op2_t       op2;
    } ctrl_t;

endpackage

// ==== design/control.sv ====
// Opcode and funct decoder, purely combinational
// Unsupported encodings flag bad and decode as a null operation
`timescale 1ns/1ps

module control (
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    output logic            bad,
    output core_pkg::ctrl_t ctrl
);
    import core_pkg::*;

    logic alt;
    logic f7_ok_op;
    logic f7_ok_imm;
    fun_t alu_fun;

    assign alt = funct7 == 7'b0100000;

    // Only add/sub and srl/sra have an alternate encoding
    assign f7_ok_op = (funct7 == 7'd0) | (alt & ((funct3 == 3'b000) | (funct3 == 3'b101)));
    assign f7_ok_imm = (funct3 == 3'b001) ? (funct7 == 7'd0) :
                       (funct3 == 3'b101) ? ((funct7 == 7'd0) | alt) : 1'b1;

    always_comb begin
        case (funct3)
            3'b000:  alu_fun = (alt && opcode == OPC_OP) ? FUN_SUB : FUN_ADD;
            3'b001:  alu_fun = FUN_SLL;
            3'b010:  alu_fun = FUN_SLT;
            3'b011:  alu_fun = FUN_SLTU;
            3'b100:  alu_fun = FUN_XOR;
            3'b101:  alu_fun = alt ? FUN_SRA : FUN_SRL;
            3'b110:  alu_fun = FUN_OR;
            default: alu_fun = FUN_AND;
        endcase
    end

    always_comb begin
        ctrl.op     = OP_NULL;
        ctrl.fun    = FUN_ADD;
        ctrl.funct3 = funct3;
        ctrl.op1    = OP1_RS1;
        ctrl.op2    = OP2_RS2;
        bad         = 1'b0;
        case (opcode)
            OPC_OP: begin
                bad = ~f7_ok_op;
                if (f7_ok_op) begin
                    ctrl.op  = OP_ALU;
                    ctrl.fun = alu_fun;
                end
            end
            OPC_OPIMM: begin
                bad = ~f7_ok_imm;
                if (f7_ok_imm) begin
                    ctrl.op  = OP_ALU;
                    ctrl.fun = alu_fun;
                    ctrl.op2 = OP2_I_IMM;
                end
            end
            OPC_LUI: begin
                ctrl.op  = OP_LUI;
                ctrl.op2 = OP2_U_IMM;
            end
            OPC_AUIPC: begin
                ctrl.op  = OP_ALU;
                ctrl.op1 = OP1_PC;
                ctrl.op2 = OP2_U_IMM;
            end
            OPC_JAL: begin
                ctrl.op  = OP_JAL;
                ctrl.op1 = OP1_PC;
                ctrl.op2 = OP2_J_IMM;
            end
            OPC_JALR: begin
                bad = funct3 != 3'b000;
                if (funct3 == 3'b000) begin
                    ctrl.op  = OP_JALR;
                    ctrl.op2 = OP2_I_IMM;
                end
            end
            OPC_BRANCH: begin
                // funct3 010 and 011 are not branch conditions
                bad = funct3[2:1] == 2'b01;
                if (funct3[2:1] != 2'b01) begin
                    ctrl.op  = OP_BRANCH;
                    ctrl.op1 = OP1_PC;
                    ctrl.op2 = OP2_B_IMM;
                end
            end
            default: bad = 1'b1;
        endcase
    end

endmodule

// ==== design/forward.sv ====
// Forwarding source select for the two decode operands
// Execute wins over retire, x0 always reads the register file
`timescale 1ns/1ps

module forward (
    input  core_pkg::addr_t rs1_addr,
    input  core_pkg::addr_t rs2_addr,
    input  core_pkg::addr_t ex_rd,
    input  logic            ex_valid,
    input  logic            ex_writes,
    input  core_pkg::addr_t wb_rd,
    input  logic            wb_valid,
    output core_pkg::rs_t   rs1_sel,
    output core_pkg::rs_t   rs2_sel
);
    import core_pkg::*;

    logic ex_on;

    // Branches and null ops in execute produce nothing to forward
    assign ex_on = ex_valid & ex_writes;

    assign rs1_sel = (rs1_addr == '0)                  ? RS_RF  :
                     (ex_on && ex_rd == rs1_addr)      ? RS_ALU :
                     (wb_valid && wb_rd == rs1_addr)   ? RS_WB  : RS_RF;

    assign rs2_sel = (rs2_addr == '0)                  ? RS_RF  :
                     (ex_on && ex_rd == rs2_addr)      ? RS_ALU :
                     (wb_valid && wb_rd == rs2_addr)   ? RS_WB  : RS_RF;

endmodule

// ==== design/regfile.sv ====
// 31 general registers, x0 reads as zero
// A write shows on a matching read port in the same cycle
`timescale 1ns/1ps

module regfile (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            we,
    input  core_pkg::addr_t waddr,
    input  core_pkg::word_t wdata,
    input  core_pkg::addr_t rs1_addr,
    input  core_pkg::addr_t rs2_addr,
    output core_pkg::word_t rs1_data,
    output core_pkg::word_t rs2_data
);
    import core_pkg::*;

    word_t regs [1:31];

    always_ff @(negedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through bypass
    assign rs1_data = (rs1_addr == '0)             ? '0    :
                      (we && waddr == rs1_addr)    ? wdata : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0)             ? '0    :
                      (we && waddr == rs2_addr)    ? wdata : regs[rs2_addr];

    // Retire never writes x0
    a_no_x0_write: assert property (@(negedge clk) disable iff (!rst_n) we |-> waddr != '0);

endmodule

// ==== design/fetch.sv ====
// Instruction fetch from a local 64-word memory loaded through a write port
// Idle after reset until start, then one word per accepted instruction
`timescale 1ns/1ps

module fetch (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic                         imem_we,
    input  logic [core_pkg::IMEM_AW-1:0] imem_addr,
    input  core_pkg::word_t              imem_wdata,
    input  logic                         redirect,
    input  core_pkg::word_t              redirect_pc,
    output logic                         if_valid,
    input  logic                         if_ready,
    output core_pkg::word_t              if_pc,
    output core_pkg::inst_t              if_ir
);
    import core_pkg::*;

    word_t imem [IMEM_DEPTH];
    logic  running;
    word_t pc;
    word_t fetch_pc;
    logic  advance;
    logic  load;

    always_ff @(negedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // A redirect replaces whatever is held in the output register
    assign fetch_pc = redirect ? redirect_pc : pc;
    assign advance  = running & (if_ready | ~if_valid);
    assign load     = ~start & (redirect | advance);

    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (start) begin
            running  <= 1'b1;
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (load) begin
            pc       <= fetch_pc + 32'd4;
            if_valid <= 1'b1;
        end
    end

    always_ff @(negedge clk) begin
        if (load) begin
            if_pc <= fetch_pc;
            if_ir <= imem[fetch_pc[IMEM_AW+1:2]];
        end
    end

    a_pc_aligned: assert property (@(negedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

// ==== design/decode.sv ====
// Decode stage, one register between fetch and execute
// Operands are forwarded from execute and retire, so no stall is needed
`timescale 1ns/1ps

module decode (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            if_valid,
    output logic            if_ready,
    input  core_pkg::word_t if_pc,
    input  core_pkg::inst_t if_ir,
    input  core_pkg::rs_t   rs1_sel,
    input  core_pkg::rs_t   rs2_sel,
    input  core_pkg::word_t alu_data,
    input  core_pkg::word_t wb_data,
    input  core_pkg::word_t rs1_data,
    input  core_pkg::word_t rs2_data,
    output core_pkg::addr_t rs1_addr,
    output core_pkg::addr_t rs2_addr,
    output logic            illegal,
    output logic            id_valid,
    input  logic            id_ready,
    output core_pkg::ctrl_t id_ctrl,
    output core_pkg::word_t id_pc,
    output core_pkg::word_t id_op1,
    output core_pkg::word_t id_op2,
    output core_pkg::word_t id_rs1,
    output core_pkg::word_t id_rs2,
    output core_pkg::addr_t id_rd
);
    import core_pkg::*;

    ctrl_t ctrl;
    logic  bad;
    word_t i_imm;
    word_t b_imm;
    word_t u_imm;
    word_t j_imm;
    word_t rs1;
    word_t rs2;
    word_t op1;
    word_t op2;

    assign rs1_addr = if_ir.r.rs1;
    assign rs2_addr = if_ir.r.rs2;

    control u_control (
        .opcode (if_ir.r.opcode),
        .funct3 (if_ir.r.funct3),
        .funct7 (if_ir.r.funct7),
        .bad    (bad),
        .ctrl   (ctrl)
    );

    // Sign-extended immediates
    assign i_imm = {{20{if_ir.i.imm_11_0[11]}}, if_ir.i.imm_11_0};
    assign b_imm = {{19{if_ir.sb.imm_12}}, if_ir.sb.imm_12, if_ir.sb.imm_11,
                    if_ir.sb.imm_10_5, if_ir.sb.imm_4_1, 1'b0};
    assign u_imm = {if_ir.u.imm_31_12, 12'd0};
    assign j_imm = {{11{if_ir.uj.imm_20}}, if_ir.uj.imm_20, if_ir.uj.imm_19_12,
                    if_ir.uj.imm_11, if_ir.uj.imm_10_1, 1'b0};

    // Forwarding muxes
    assign rs1 = (rs1_sel == RS_ALU) ? alu_data : (rs1_sel == RS_WB) ? wb_data : rs1_data;
    assign rs2 = (rs2_sel == RS_ALU) ? alu_data : (rs2_sel == RS_WB) ? wb_data : rs2_data;

    assign op1 = (ctrl.op1 == OP1_PC) ? if_pc : rs1;

    always_comb begin
        case (ctrl.op2)
            OP2_I_IMM: op2 = i_imm;
            OP2_B_IMM: op2 = b_imm;
            OP2_U_IMM: op2 = u_imm;
            OP2_J_IMM: op2 = j_imm;
            default:   op2 = rs2;
        endcase
    end

    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (flush) begin
            id_valid <= 1'b0;
        end else if (id_ready) begin
            id_valid <= if_valid;
        end
    end

    always_ff @(negedge clk) begin
        if (id_ready) begin
            id_ctrl <= ctrl;
            id_pc   <= if_pc;
            id_op1  <= op1;
            id_op2  <= op2;
            id_rs1  <= rs1;
            id_rs2  <= rs2;
            id_rd   <= if_ir.r.rd;
        end
    end

    assign if_ready = id_ready;
    assign illegal  = bad & if_valid;

    a_valid_known: assert property (@(negedge clk) disable iff (!rst_n) !$isunknown(id_valid));

endmodule

// ==== design/execute.sv ====
// ALU, branch resolution and the retire register
// Branches and null ops leave no retire entry
`timescale 1ns/1ps

module execute (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            id_valid,
    output logic            id_ready,
    input  core_pkg::ctrl_t id_ctrl,
    input  core_pkg::word_t id_pc,
    input  core_pkg::word_t id_op1,
    input  core_pkg::word_t id_op2,
    input  core_pkg::word_t id_rs1,
    input  core_pkg::word_t id_rs2,
    input  core_pkg::addr_t id_rd,
    output core_pkg::word_t alu_data,
    output logic            redirect,
    output core_pkg::word_t redirect_pc,
    output logic            ret_valid,
    input  logic            ret_ready,
    output core_pkg::word_t ret_pc,
    output core_pkg::addr_t ret_rd,
    output core_pkg::word_t ret_data,
    output logic            rf_we
);
    import core_pkg::*;

    word_t alu_res;
    word_t sum;
    logic  taken;
    logic  accept;
    logic  writes;

    assign sum = id_op1 + id_op2;

    always_comb begin
        case (id_ctrl.fun)
            FUN_SUB:  alu_res = id_op1 - id_op2;
            FUN_AND:  alu_res = id_op1 & id_op2;
            FUN_OR:   alu_res = id_op1 | id_op2;
            FUN_XOR:  alu_res = id_op1 ^ id_op2;
            FUN_SLT:  alu_res = {31'd0, $signed(id_op1) < $signed(id_op2)};
            FUN_SLTU: alu_res = {31'd0, id_op1 < id_op2};
            FUN_SLL:  alu_res = id_op1 << id_op2[4:0];
            FUN_SRL:  alu_res = id_op1 >> id_op2[4:0];
            FUN_SRA:  alu_res = word_t'($signed(id_op1) >>> id_op2[4:0]);
            default:  alu_res = sum;
        endcase
    end

    // Jumps link pc+4, LUI passes the immediate
    always_comb begin
        case (id_ctrl.op)
            OP_JAL, OP_JALR: alu_data = id_pc + 32'd4;
            OP_LUI:          alu_data = id_op2;
            default:         alu_data = alu_res;
        endcase
    end

    always_comb begin
        case (id_ctrl.funct3)
            3'b000:  taken = id_rs1 == id_rs2;
            3'b001:  taken = id_rs1 != id_rs2;
            3'b100:  taken = $signed(id_rs1) < $signed(id_rs2);
            3'b101:  taken = $signed(id_rs1) >= $signed(id_rs2);
            3'b110:  taken = id_rs1 < id_rs2;
            3'b111:  taken = id_rs1 >= id_rs2;
            default: taken = 1'b0;
        endcase
    end

    assign id_ready = ~ret_valid | ret_ready;
    assign accept   = id_valid & id_ready;
    assign writes   = (id_ctrl.op != OP_NULL) & (id_ctrl.op != OP_BRANCH);

    assign redirect = accept & (((id_ctrl.op == OP_BRANCH) & taken) |
                                (id_ctrl.op == OP_JAL) | (id_ctrl.op == OP_JALR));
    assign redirect_pc = (id_ctrl.op == OP_JALR) ? {sum[31:1], 1'b0} : sum;

    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ret_valid <= 1'b0;
        end else if (id_ready) begin
            ret_valid <= id_valid & writes;
        end
    end

    always_ff @(negedge clk) begin
        if (accept) begin
            ret_pc   <= id_pc;
            ret_rd   <= id_rd;
            ret_data <= alu_data;
        end
    end

    assign rf_we = ret_valid & ret_ready & (ret_rd != '0);

    // Decode must drop the wrong-path instruction right after a redirect
    a_redirect: assert property (@(negedge clk) disable iff (!rst_n)
        redirect |-> id_valid ##1 !id_valid);

endmodule

// ==== design/rv_int_core.sv ====
// RV32I integer datapath top, fetch to retire in three register stages
// The instruction memory must be loaded before start is pulsed
`timescale 1ns/1ps

module rv_int_core (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         imem_we,
    input  logic [core_pkg::IMEM_AW-1:0] imem_addr,
    input  core_pkg::word_t              imem_wdata,
    input  logic                         start,
    output logic                         ret_valid,
    input  logic                         ret_ready,
    output core_pkg::word_t              ret_pc,
    output core_pkg::addr_t              ret_rd,
    output core_pkg::word_t              ret_data,
    output logic                         illegal
);
    import core_pkg::*;

    logic  if_valid;
    logic  if_ready;
    word_t if_pc;
    inst_t if_ir;
    logic  id_valid;
    logic  id_ready;
    ctrl_t id_ctrl;
    word_t id_pc;
    word_t id_op1;
    word_t id_op2;
    word_t id_rs1;
    word_t id_rs2;
    addr_t id_rd;
    addr_t rs1_addr;
    addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;
    rs_t   rs1_sel;
    rs_t   rs2_sel;
    word_t alu_data;
    logic  redirect;
    word_t redirect_pc;
    logic  rf_we;
    logic  ex_writes;

    // Only result-producing classes can be forwarded from execute
    assign ex_writes = (id_ctrl.op != OP_NULL) && (id_ctrl.op != OP_BRANCH);

    fetch u_fetch (
        .clk, .rst_n, .start, .imem_we, .imem_addr, .imem_wdata,
        .redirect, .redirect_pc, .if_valid, .if_ready, .if_pc, .if_ir
    );

    decode u_decode (
        .clk, .rst_n, .flush(redirect), .if_valid, .if_ready, .if_pc, .if_ir,
        .rs1_sel, .rs2_sel, .alu_data, .wb_data(ret_data), .rs1_data, .rs2_data,
        .rs1_addr, .rs2_addr, .illegal, .id_valid, .id_ready, .id_ctrl, .id_pc,
        .id_op1, .id_op2, .id_rs1, .id_rs2, .id_rd
    );

    forward u_forward (
        .rs1_addr, .rs2_addr, .ex_rd(id_rd), .ex_valid(id_valid), .ex_writes,
        .wb_rd(ret_rd), .wb_valid(ret_valid), .rs1_sel, .rs2_sel
    );

    regfile u_regfile (
        .clk, .rst_n, .we(rf_we), .waddr(ret_rd), .wdata(ret_data),
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data
    );

    execute u_execute (
        .clk, .rst_n, .id_valid, .id_ready, .id_ctrl, .id_pc, .id_op1, .id_op2,
        .id_rs1, .id_rs2, .id_rd, .alu_data, .redirect, .redirect_pc,
        .ret_valid, .ret_ready, .ret_pc, .ret_rd, .ret_data, .rf_we
    );

endmodule

// ==== verif/rv_int_core_tb.sv ====
// Directed tests for the RV32I datapath, checked against an ISA reference model
// Programs must write every register before reading it as the regfile has no reset
`timescale 1ns/1ps

module rv_int_core_tb;
    import core_pkg::*;

    localparam int          MAX_CYCLES = 2000;
    localparam logic [31:0] SEED       = 32'h15af537d;

    logic               clk;
    logic               rst_n;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    logic [31:0]        imem_wdata;
    logic               start;
    logic               ret_valid;
    logic               ret_ready;
    logic [31:0]        ret_pc;
    logic [4:0]         ret_rd;
    logic [31:0]        ret_data;
    logic               illegal;

    logic [31:0] prog [IMEM_DEPTH];
    int          prog_len;
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] rng;
    int          cycles;
    int          lat;
    bit          ill;

    rv_int_core dut (
        .clk, .rst_n, .imem_we, .imem_addr, .imem_wdata, .start,
        .ret_valid, .ret_ready, .ret_pc, .ret_rd, .ret_data, .illegal
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Instruction encoders
    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] btype(input int off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        logic [12:0] b;
        b = off[12:0];
        return {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jtype(input int off, input logic [4:0] rd);
        logic [20:0] j;
        j = off[20:0];
        return {j[20], j[10:1], j[11], j[19:12], rd, OPC_JAL};
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s expected %h actual %h", test, what, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic cycle_step();
        @(posedge clk);
        #5;
    endtask

    task automatic reset_core();
        rst_n = 1'b0;
        repeat (4) cycle_step();
        rst_n = 1'b1;
    endtask

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // Unused words branch back to the end loop at word prog_len
    task automatic load_program();
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            cycle_step();
            imem_we    = 1'b1;
            imem_addr  = a[IMEM_AW-1:0];
            imem_wdata = (a < prog_len) ? prog[a] : btype((prog_len - a) * 4, 5'd0, 5'd0, 3'd0);
        end
        cycle_step();
        imem_we = 1'b0;
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input bit alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res;
        case (f3)
            3'd0: res = alt ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // ISA reference model that fills the expected retire list
    task automatic model_run();
        logic [31:0] r [32];
        logic [31:0] pc;
        logic [31:0] nxt;
        logic [31:0] ir;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [2:0]  f3;
        logic [6:0]  f7;
        bit          wr;
        bit          ok;
        bit          tk;
        int          n;
        for (int k = 0; k < 32; k++) r[k] = '0;
        exp_pc.delete();
        exp_rd.delete();
        exp_data.delete();
        pc = '0;
        n  = 0;
        while (pc != prog_len * 4 && n < 200) begin
            ir  = prog[pc[7:2]];
            f3  = ir[14:12];
            f7  = ir[31:25];
            a   = r[ir[19:15]];
            b   = r[ir[24:20]];
            wr  = 1'b0;
            nxt = pc + 4;
            case (ir[6:0])
                OPC_OP: begin
                    ok  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                    wr  = ok;
                    res = alu_ref(f3, f7[5], a, b);
                end
                OPC_OPIMM: begin
                    b   = {{20{ir[31]}}, ir[31:20]};
                    ok  = (f3 == 3'd1) ? (f7 == 7'h00) :
                          (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
                    wr  = ok;
                    res = alu_ref(f3, (f3 == 3'd5) && f7[5], a, b);
                end
                OPC_LUI: begin
                    wr  = 1'b1;
                    res = {ir[31:12], 12'd0};
                end
                OPC_AUIPC: begin
                    wr  = 1'b1;
                    res = pc + {ir[31:12], 12'd0};
                end
                OPC_JAL: begin
                    wr  = 1'b1;
                    res = pc + 4;
                    nxt = pc + {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
                end
                OPC_JALR: begin
                    if (f3 == 3'd0) begin
                        wr  = 1'b1;
                        res = pc + 4;
                        nxt = (a + {{20{ir[31]}}, ir[31:20]}) & ~32'd1;
                    end
                end
                OPC_BRANCH: begin
                    case (f3)
                        3'd0: tk = a == b;
                        3'd1: tk = a != b;
                        3'd4: tk = $signed(a) < $signed(b);
                        3'd5: tk = $signed(a) >= $signed(b);
                        3'd6: tk = a < b;
                        3'd7: tk = a >= b;
                        default: tk = 1'b0;
                    endcase
                    if (tk) nxt = pc + {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                exp_pc.push_back(pc);
                exp_rd.push_back(ir[11:7]);
                exp_data.push_back(res);
                if (ir[11:7] != 5'd0) r[ir[11:7]] = res;
            end
            pc = nxt;
            n++;
        end
        if (n >= 200) fail_now("Reference model never reached the end of the program");
    endtask

    // Pulses start, then checks every retire transfer against the model
    task automatic run_program(input string name, input bit stall, output int first,
                               output bit seen_ill);
        int idx;
        int steps;
        idx      = 0;
        steps    = 0;
        first    = -1;
        seen_ill = 1'b0;
        model_run();
        cycle_step();
        start     = 1'b1;
        ret_ready = 1'b1;
        while (idx < exp_pc.size()) begin
            cycle_step();
            start = 1'b0;
            steps++;
            if (stall) begin
                rng       = xorshift(rng);
                ret_ready = rng[7];
            end
            if (illegal) seen_ill = 1'b1;
            if (ret_valid && first < 0) first = steps;
            if (ret_valid && ret_ready) begin
                check_value(name, "ret_pc", exp_pc[idx], ret_pc);
                check_value(name, "ret_rd", exp_rd[idx], ret_rd);
                check_value(name, "ret_data", exp_data[idx], ret_data);
                idx++;
            end
        end
        ret_ready = 1'b1;
        repeat (8) begin
            cycle_step();
            if (ret_valid) fail_now("Extra retire after the last expected instruction");
        end
    endtask

    // Same program on every call
    task automatic build_alu();
        logic [31:0] s;
        s        = SEED;
        prog_len = 0;
        for (int k = 1; k <= 6; k++) begin
            s = xorshift(s);
            emit(utype(s[31:12], k[4:0], OPC_LUI));
            emit(itype(s[11:0], k[4:0], 3'd0, k[4:0], OPC_OPIMM));
        end
        emit(rtype(7'h00, 5'd2, 5'd1, 3'd0, 5'd7));
        emit(rtype(7'h20, 5'd2, 5'd1, 3'd0, 5'd8));
        for (int f = 1; f < 8; f++) begin
            emit(rtype(7'h00, 5'd3, 5'd4, f[2:0], 5'd9));
        end
        emit(rtype(7'h20, 5'd5, 5'd6, 3'd5, 5'd10));
        for (int f = 0; f < 8; f++) begin
            s = xorshift(s);
            if (f == 1 || f == 5) emit(itype({7'h00, s[4:0]}, 5'd6, f[2:0], 5'd11, OPC_OPIMM));
            else emit(itype(s[11:0], 5'd5, f[2:0], 5'd11, OPC_OPIMM));
        end
        emit(itype({7'h20, s[9:5]}, 5'd6, 3'd5, 5'd12, OPC_OPIMM));
        emit(utype(s[31:12], 5'd13, OPC_AUIPC));
    endtask

    task automatic alu_and_imm(input bit stall, input string name);
        reset_core();
        build_alu();
        load_program();
        run_program(name, stall, lat, ill);
        check_value(name, "illegal seen", 32'd0, {31'd0, ill});
    endtask

    task automatic forwarding();
        reset_core();
        prog_len = 0;
        emit(itype(12'd5, 5'd0, 3'd0, 5'd1, OPC_OPIMM));
        emit(rtype(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
        emit(itype(12'd9, 5'd0, 3'd0, 5'd4, OPC_OPIMM));
        emit(itype(12'd1, 5'd0, 3'd0, 5'd5, OPC_OPIMM));
        emit(rtype(7'h00, 5'd4, 5'd4, 3'd0, 5'd6));
        emit(itype(12'd3, 5'd0, 3'd0, 5'd7, OPC_OPIMM));
        emit(itype(12'd2, 5'd0, 3'd0, 5'd8, OPC_OPIMM));
        emit(itype(12'd4, 5'd0, 3'd0, 5'd9, OPC_OPIMM));
        emit(rtype(7'h00, 5'd8, 5'd7, 3'd0, 5'd10));
        emit(rtype(7'h20, 5'd9, 5'd10, 3'd0, 5'd11));
        emit(rtype(7'h00, 5'd2, 5'd11, 3'd6, 5'd12));
        load_program();
        run_program("forward", 1'b0, lat, ill);
    endtask

    // Taken branches skip the marker write to x10
    task automatic branch_skip(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input logic [11:0] mark);
        emit(btype(8, rs2, rs1, f3));
        emit(itype(mark, 5'd0, 3'd0, 5'd10, OPC_OPIMM));
    endtask

    task automatic branches_and_jumps();
        int p;
        reset_core();
        prog_len = 0;
        emit(itype(12'd5, 5'd0, 3'd0, 5'd1, OPC_OPIMM));
        emit(itype(12'hffd, 5'd0, 3'd0, 5'd2, OPC_OPIMM));
        emit(itype(12'd5, 5'd0, 3'd0, 5'd3, OPC_OPIMM));
        branch_skip(3'd0, 5'd1, 5'd3, 12'd1);
        branch_skip(3'd0, 5'd1, 5'd2, 12'd2);
        branch_skip(3'd1, 5'd1, 5'd2, 12'd3);
        branch_skip(3'd1, 5'd1, 5'd3, 12'd4);
        branch_skip(3'd4, 5'd2, 5'd1, 12'd5);
        branch_skip(3'd4, 5'd1, 5'd2, 12'd6);
        branch_skip(3'd5, 5'd1, 5'd2, 12'd7);
        branch_skip(3'd5, 5'd2, 5'd1, 12'd8);
        branch_skip(3'd6, 5'd1, 5'd2, 12'd9);
        branch_skip(3'd6, 5'd2, 5'd1, 12'd10);
        branch_skip(3'd7, 5'd2, 5'd1, 12'd11);
        branch_skip(3'd7, 5'd1, 5'd2, 12'd12);
        emit(jtype(8, 5'd5));
        emit(itype(12'd50, 5'd0, 3'd0, 5'd10, OPC_OPIMM));
        p = prog_len * 4;
        // Odd target checks that JALR clears bit 0
        emit(itype(p + 13, 5'd0, 3'd0, 5'd4, OPC_OPIMM));
        emit(itype(12'd0, 5'd4, 3'd0, 5'd6, OPC_JALR));
        emit(itype(12'd60, 5'd0, 3'd0, 5'd10, OPC_OPIMM));
        emit(itype(12'd1, 5'd6, 3'd0, 5'd11, OPC_OPIMM));
        emit(rtype(7'h00, 5'd5, 5'd11, 3'd0, 5'd12));
        load_program();
        run_program("branch", 1'b0, lat, ill);
    endtask

    task automatic illegal_opcode();
        reset_core();
        prog_len = 0;
        emit(itype(12'd1, 5'd0, 3'd0, 5'd1, OPC_OPIMM));
        // Undefined opcode whose rd field names the next source register
        emit(32'h0000_00ff);
        emit(itype(12'd2, 5'd1, 3'd0, 5'd2, OPC_OPIMM));
        emit(rtype(7'h00, 5'd1, 5'd2, 3'd0, 5'd3));
        load_program();
        run_program("illegal", 1'b0, lat, ill);
        check_value("illegal", "illegal seen", 32'd1, {31'd0, ill});
    endtask

    task automatic retire_latency();
        reset_core();
        prog_len = 0;
        emit(itype(12'd42, 5'd0, 3'd0, 5'd1, OPC_OPIMM));
        load_program();
        run_program("latency", 1'b0, lat, ill);
        check_value("latency", "cycles to first retire", 32'd4, lat);
    endtask

    initial begin
        rst_n      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        start      = 1'b0;
        ret_ready  = 1'b1;
        cycles     = 0;
        prog_len   = 0;
        rng        = SEED;
        alu_and_imm(1'b0, "alu_imm");
        forwarding();
        branches_and_jumps();
        alu_and_imm(1'b1, "backpressure");
        illegal_opcode();
        retire_latency();
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== rv_int_core.f ====
design/core_pkg.sv
design/control.sv
design/forward.sv
design/regfile.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/rv_int_core.sv
verif/rv_int_core_tb.sv
